// File: mfp_pkg.sv
package mfp_pkg;

    // request from the bus master, one word per transfer
    typedef struct packed {
        logic [31:0] addr;    // byte address, word aligned
        logic [31:0] wdata;
        logic        write;   // 1 = write, 0 = read
        logic [3:0]  strb;    // byte strobes for writes
    } bus_req_t;

    // response, one cycle after acceptance at the earliest
    typedef struct packed {
        logic [31:0] rdata;
        logic        err;     // set for unmapped addresses
    } bus_rsp_t;

    // address map
    localparam logic [31:0] MFP_RAM_BASE  = 32'h0000_0000;  // decoded on addr[31:28]
    localparam logic [31:0] MFP_GPIO_BASE = 32'h1F80_0000;
    localparam logic [31:0] MFP_EIC_BASE  = 32'h1F80_1000;
    localparam int          MFP_WIN_BITS  = 12;             // 4 KB peripheral windows

    // gpio register offsets inside its window
    localparam logic [MFP_WIN_BITS-1:0] GPIO_RED     = 12'h000;
    localparam logic [MFP_WIN_BITS-1:0] GPIO_GREEN   = 12'h004;
    localparam logic [MFP_WIN_BITS-1:0] GPIO_HEX     = 12'h008;
    localparam logic [MFP_WIN_BITS-1:0] GPIO_SW      = 12'h00C;  // read only
    localparam logic [MFP_WIN_BITS-1:0] GPIO_BTN     = 12'h010;  // read only
    localparam logic [MFP_WIN_BITS-1:0] GPIO_BTN_INT = 12'h014;  // sticky, write clears

    // eic register offsets
    localparam logic [MFP_WIN_BITS-1:0] EIC_MASK  = 12'h000;
    localparam logic [MFP_WIN_BITS-1:0] EIC_PEND  = 12'h004;     // read only
    localparam logic [MFP_WIN_BITS-1:0] EIC_SWINT = 12'h008;     // bits 1:0 set sw pending
    localparam logic [MFP_WIN_BITS-1:0] EIC_VEC   = 12'h00C;     // {valid, vector}

    // board widths
    localparam int MFP_N_RED_LEDS   = 10;
    localparam int MFP_N_GREEN_LEDS = 8;
    localparam int MFP_N_SWITCHES   = 10;
    localparam int MFP_N_BUTTONS    = 4;
    localparam int MFP_HEX_WIDTH    = 32;

    // interrupt channels, 7 is the highest priority
    localparam int MFP_EIC_CHANNELS = 8;
    localparam int EIC_CH_SW0       = 0;
    localparam int EIC_CH_SW1       = 1;
    localparam int EIC_CH_BTN       = 5;   // button edge from gpio
    localparam int EIC_CH_EXT       = 7;   // external line

    typedef logic [2:0] irq_vec_t;

    // cycles the reset outputs stay up after the source goes away
    localparam int MFP_RESET_HOLD = 4;

endpackage

// File: mfp_reset.sv
module mfp_reset (
    input  logic hclk,
    input  logic rst,            // cold reset source
    input  logic pin_rst_soft,   // asynchronous soft reset pin
    output logic si_cold_reset,
    output logic si_reset
);
    localparam int CNT_W = $clog2(mfp_pkg::MFP_RESET_HOLD + 1);

    logic [1:0]       cold_sync;  // two flop synchronizers
    logic [1:0]       soft_sync;
    logic [CNT_W-1:0] cold_cnt;   // hold counter for cold only
    logic [CNT_W-1:0] any_cnt;    // hold counter for cold or soft
    logic             cold_on;
    logic             any_on;

    assign cold_on = cold_sync[1];
    assign any_on  = cold_sync[1] | soft_sync[1];

    // synchronizers and hold counters
    always_ff @(posedge hclk) begin
        cold_sync <= {cold_sync[0], rst};
        soft_sync <= {soft_sync[0], pin_rst_soft};

        if (cold_on)
            cold_cnt <= CNT_W'(mfp_pkg::MFP_RESET_HOLD);  // reload while active
        else if (cold_cnt != '0)
            cold_cnt <= cold_cnt - 1'b1;

        if (any_on)
            any_cnt <= CNT_W'(mfp_pkg::MFP_RESET_HOLD);
        else if (any_cnt != '0)
            any_cnt <= any_cnt - 1'b1;
    end

    assign si_cold_reset = cold_on | (cold_cnt != '0);  // up two cycles after rst rises
    assign si_reset      = any_on | (any_cnt != '0);

    // cold reset must always reach the whole system
    a_cold_in_reset: assert property (@(posedge hclk) si_cold_reset |-> si_reset);

endmodule

// File: mfp_bus_matrix.sv
module mfp_bus_matrix (
    input  logic              hclk,
    input  logic              rst,
    input  mfp_pkg::bus_req_t req,
    input  logic              req_valid,
    output logic              req_ready,
    output mfp_pkg::bus_rsp_t rsp,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output mfp_pkg::bus_req_t slave_req,   // shared by all slaves
    output logic              ram_sel,
    output logic              gpio_sel,
    output logic              eic_sel,
    input  logic [31:0]       ram_rdata,
    input  logic [31:0]       gpio_rdata,
    input  logic [31:0]       eic_rdata
);
    localparam int WB = mfp_pkg::MFP_WIN_BITS;

    typedef enum logic [1:0] {TGT_RAM, TGT_GPIO, TGT_EIC, TGT_NONE} target_e;

    logic              accept;
    target_e           target;     // decode of the incoming address
    target_e           target_q;   // slave owning the response in flight
    logic              fresh;      // first response cycle, data straight from the slave
    mfp_pkg::bus_rsp_t rsp_live;
    mfp_pkg::bus_rsp_t rsp_q;      // held copy under back-pressure

    assign req_ready = !rsp_valid || rsp_ready;  // one item in flight at most
    assign accept    = req_valid && req_ready;
    assign slave_req = req;

    always_comb begin
        if (req.addr[31:28] == mfp_pkg::MFP_RAM_BASE[31:28])
            target = TGT_RAM;                    // upper ram region wraps
        else if (req.addr[31:WB] == mfp_pkg::MFP_GPIO_BASE[31:WB])
            target = TGT_GPIO;
        else if (req.addr[31:WB] == mfp_pkg::MFP_EIC_BASE[31:WB])
            target = TGT_EIC;
        else
            target = TGT_NONE;
    end

    // one cycle pulses, nothing selected for unmapped
    assign ram_sel  = accept && (target == TGT_RAM);
    assign gpio_sel = accept && (target == TGT_GPIO);
    assign eic_sel  = accept && (target == TGT_EIC);

    always_comb begin
        rsp_live = '0;
        case (target_q)
            TGT_RAM:  rsp_live.rdata = ram_rdata;
            TGT_GPIO: rsp_live.rdata = gpio_rdata;
            TGT_EIC:  rsp_live.rdata = eic_rdata;
            default:  rsp_live.err   = 1'b1;     // zero data with error
        endcase
    end

    always_ff @(posedge hclk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            fresh     <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;                   // valid the cycle after acceptance
            fresh     <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
            fresh     <= 1'b0;
        end else begin
            fresh     <= 1'b0;                   // stalled, switch to the held copy
        end
    end

    always_ff @(posedge hclk) begin
        if (accept)
            target_q <= target;
        if (fresh)
            rsp_q <= rsp_live;
    end

    assign rsp = fresh ? rsp_live : rsp_q;

    a_one_sel: assert property (@(posedge hclk) disable iff (rst)
        $onehot0({ram_sel, gpio_sel, eic_sel}));
    a_rsp_hold: assert property (@(posedge hclk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

// File: mfp_ram.sv
module mfp_ram #(
    parameter int RAM_ADDR_BITS = 8      // word address width
) (
    input  logic              hclk,
    input  logic              sel,
    input  mfp_pkg::bus_req_t slave_req,
    output logic [31:0]       rdata
);
    localparam int DEPTH = 2 ** RAM_ADDR_BITS;

    logic [31:0]              mem [DEPTH];
    logic [RAM_ADDR_BITS-1:0] word_addr;  // upper address bits ignored

    assign word_addr = slave_req.addr[RAM_ADDR_BITS+1:2];

    // byte lanes written by strobe, read data registered on every select
    always_ff @(posedge hclk) begin
        if (sel) begin
            if (slave_req.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (slave_req.strb[b])
                        mem[word_addr][8*b +: 8] <= slave_req.wdata[8*b +: 8];
                end
            end
            rdata <= mem[word_addr];          // old word on a write
        end
    end

endmodule

// File: mfp_gpio.sv
module mfp_gpio (
    input  logic                                hclk,
    input  logic                                rst,          // cold reset only
    input  logic                                sel,
    input  mfp_pkg::bus_req_t                   slave_req,
    input  logic [mfp_pkg::MFP_N_SWITCHES-1:0]  io_switches,
    input  logic [mfp_pkg::MFP_N_BUTTONS-1:0]   io_buttons,
    output logic [31:0]                         rdata,
    output logic [mfp_pkg::MFP_N_RED_LEDS-1:0]  io_red_leds,
    output logic [mfp_pkg::MFP_N_GREEN_LEDS-1:0] io_green_leds,
    output logic [mfp_pkg::MFP_HEX_WIDTH-1:0]   io_hex,
    output logic                                btn_int       // sticky button edge flag
);
    logic [mfp_pkg::MFP_WIN_BITS-1:0]  offset;
    logic                              wr;
    logic [mfp_pkg::MFP_N_SWITCHES-1:0] sw_q;       // sampled every cycle
    logic [mfp_pkg::MFP_N_BUTTONS-1:0]  btn_q;
    logic [mfp_pkg::MFP_N_BUTTONS-1:0]  btn_prev;   // for edge detect
    logic                              btn_rise;

    assign offset   = slave_req.addr[mfp_pkg::MFP_WIN_BITS-1:0];
    assign wr       = sel && slave_req.write;
    assign btn_rise = |(btn_q & ~btn_prev);

    always_ff @(posedge hclk) begin
        sw_q     <= io_switches;
        btn_q    <= io_buttons;
        btn_prev <= btn_q;
    end

    always_ff @(posedge hclk) begin
        if (rst) begin
            io_red_leds   <= '0;
            io_green_leds <= '0;
            io_hex        <= '0;
            btn_int       <= 1'b0;
        end else begin
            if (wr && offset == mfp_pkg::GPIO_RED)
                io_red_leds <= slave_req.wdata[mfp_pkg::MFP_N_RED_LEDS-1:0];  // full word
            if (wr && offset == mfp_pkg::GPIO_GREEN)
                io_green_leds <= slave_req.wdata[mfp_pkg::MFP_N_GREEN_LEDS-1:0];
            if (wr && offset == mfp_pkg::GPIO_HEX) begin
                for (int b = 0; b < mfp_pkg::MFP_HEX_WIDTH / 8; b++) begin
                    if (slave_req.strb[b])
                        io_hex[8*b +: 8] <= slave_req.wdata[8*b +: 8];
                end
            end
            if (btn_rise)
                btn_int <= 1'b1;                 // a new edge beats a clear
            else if (wr && offset == mfp_pkg::GPIO_BTN_INT)
                btn_int <= 1'b0;
        end
    end

    always_ff @(posedge hclk) begin
        if (sel) begin
            case (offset)
                mfp_pkg::GPIO_RED:     rdata <= 32'(io_red_leds);
                mfp_pkg::GPIO_GREEN:   rdata <= 32'(io_green_leds);
                mfp_pkg::GPIO_HEX:     rdata <= 32'(io_hex);
                mfp_pkg::GPIO_SW:      rdata <= 32'(sw_q);    // one cycle old
                mfp_pkg::GPIO_BTN:     rdata <= 32'(btn_q);
                mfp_pkg::GPIO_BTN_INT: rdata <= 32'(btn_int);
                default:               rdata <= 32'h0;
            endcase
        end
    end

endmodule

// File: mfp_eic.sv
module mfp_eic (
    input  logic              hclk,
    input  logic              rst,         // system reset, cold or soft
    input  logic              sel,
    input  mfp_pkg::bus_req_t slave_req,
    input  logic              btn_int,     // channel 5
    input  logic              ext_irq,     // channel 7
    input  logic              irq_ack,
    output logic [31:0]       rdata,
    output logic              irq_valid,
    output mfp_pkg::irq_vec_t irq_vector
);
    localparam int CH = mfp_pkg::MFP_EIC_CHANNELS;

    logic [mfp_pkg::MFP_WIN_BITS-1:0] offset;
    logic                             wr;
    logic [CH-1:0]                    mask;      // 1 enables the channel
    logic [CH-1:0]                    pend;
    logic [CH-1:0]                    active;    // pending and enabled
    logic [CH-1:0]                    set;       // new events this cycle
    logic [CH-1:0]                    clr;       // acknowledged channel
    logic                             btn_prev;
    logic                             ext_prev;

    assign offset = slave_req.addr[mfp_pkg::MFP_WIN_BITS-1:0];
    assign wr     = sel && slave_req.write;
    assign active = pend & mask;

    always_comb begin
        set = '0;
        set[mfp_pkg::EIC_CH_SW0] = wr && offset == mfp_pkg::EIC_SWINT && slave_req.wdata[0];
        set[mfp_pkg::EIC_CH_SW1] = wr && offset == mfp_pkg::EIC_SWINT && slave_req.wdata[1];
        set[mfp_pkg::EIC_CH_BTN] = btn_int & ~btn_prev;   // rising edges only
        set[mfp_pkg::EIC_CH_EXT] = ext_irq & ~ext_prev;
    end

    // highest numbered active channel wins
    always_comb begin
        irq_vector = '0;
        for (int i = 0; i < CH; i++) begin
            if (active[i])
                irq_vector = mfp_pkg::irq_vec_t'(i);
        end
    end

    assign irq_valid = |active;
    assign clr       = (irq_valid && irq_ack) ? CH'(1) << irq_vector : '0;

    always_ff @(posedge hclk) begin
        btn_prev <= btn_int;
        ext_prev <= ext_irq;
    end

    always_ff @(posedge hclk) begin
        if (rst) begin
            mask <= '0;
            pend <= '0;
        end else begin
            if (wr && offset == mfp_pkg::EIC_MASK)
                mask <= slave_req.wdata[CH-1:0];
            pend <= (pend & ~clr) | set;          // set wins over ack
        end
    end

    always_ff @(posedge hclk) begin
        if (sel) begin
            case (offset)
                mfp_pkg::EIC_MASK: rdata <= 32'(mask);
                mfp_pkg::EIC_PEND: rdata <= 32'(pend);
                mfp_pkg::EIC_VEC:  rdata <= 32'({irq_valid, irq_vector});  // bit 3 valid
                default:           rdata <= 32'h0;
            endcase
        end
    end

    // master side contract, ack only on a presented vector
    a_ack_valid: assert property (@(posedge hclk) disable iff (rst) irq_ack |-> irq_valid);

endmodule

// File: mfp_system.sv
module mfp_system #(
    parameter int RAM_ADDR_BITS = 8
) (
    input  logic                                 hclk,
    input  logic                                 rst,
    input  logic                                 pin_rst_soft,
    input  mfp_pkg::bus_req_t                    req,
    input  logic                                 req_valid,
    output logic                                 req_ready,
    output mfp_pkg::bus_rsp_t                    rsp,
    output logic                                 rsp_valid,
    input  logic                                 rsp_ready,
    input  logic [mfp_pkg::MFP_N_SWITCHES-1:0]   io_switches,
    input  logic [mfp_pkg::MFP_N_BUTTONS-1:0]    io_buttons,
    output logic [mfp_pkg::MFP_N_RED_LEDS-1:0]   io_red_leds,
    output logic [mfp_pkg::MFP_N_GREEN_LEDS-1:0] io_green_leds,
    output logic [mfp_pkg::MFP_HEX_WIDTH-1:0]    io_hex,
    input  logic                                 ext_irq,
    input  logic                                 irq_ack,
    output logic                                 irq_valid,
    output mfp_pkg::irq_vec_t                    irq_vector,
    output logic                                 si_cold_reset,
    output logic                                 si_reset
);
    mfp_pkg::bus_req_t slave_req;
    logic              ram_sel;
    logic              gpio_sel;
    logic              eic_sel;
    logic [31:0]       ram_rdata;
    logic [31:0]       gpio_rdata;
    logic [31:0]       eic_rdata;
    logic              btn_int;    // gpio to eic channel 5

    mfp_reset mfp_reset_inst (.hclk, .rst, .pin_rst_soft, .si_cold_reset, .si_reset);

    mfp_bus_matrix mfp_bus_matrix_inst (
        .hclk, .rst (si_reset), .req, .req_valid, .req_ready, .rsp, .rsp_valid, .rsp_ready,
        .slave_req, .ram_sel, .gpio_sel, .eic_sel, .ram_rdata, .gpio_rdata, .eic_rdata
    );

    mfp_ram #(.RAM_ADDR_BITS (RAM_ADDR_BITS)) mfp_ram_inst (
        .hclk, .sel (ram_sel), .slave_req, .rdata (ram_rdata)
    );

    // leds keep their state over a soft reset
    mfp_gpio mfp_gpio_inst (
        .hclk, .rst (si_cold_reset), .sel (gpio_sel), .slave_req, .io_switches, .io_buttons,
        .rdata (gpio_rdata), .io_red_leds, .io_green_leds, .io_hex, .btn_int
    );

    mfp_eic mfp_eic_inst (
        .hclk, .rst (si_reset), .sel (eic_sel), .slave_req, .btn_int, .ext_irq, .irq_ack,
        .rdata (eic_rdata), .irq_valid, .irq_vector
    );

endmodule

// File: tb_mfp_system.sv
module tb_mfp_system;

    localparam int RAM_ADDR_BITS = 8;
    localparam int PERIOD        = 40;
    localparam int N_RAM         = 8;      // ram words exercised
    localparam int N_XFERS       = 3 * N_RAM + 1 + 8 + 3 + 5 + 3;  // bus transfers in all tests
    localparam int RESET_TIME    = (4 + mfp_pkg::MFP_RESET_HOLD + 4) * PERIOD;
    localparam logic [31:0] GPIO = mfp_pkg::MFP_GPIO_BASE;
    localparam logic [31:0] EIC  = mfp_pkg::MFP_EIC_BASE;

    logic                                 hclk;
    logic                                 rst;
    logic                                 pin_rst_soft;
    mfp_pkg::bus_req_t                    req;
    logic                                 req_valid;
    logic                                 req_ready;
    mfp_pkg::bus_rsp_t                    rsp;
    logic                                 rsp_valid;
    logic                                 rsp_ready;
    logic [mfp_pkg::MFP_N_SWITCHES-1:0]   io_switches;
    logic [mfp_pkg::MFP_N_BUTTONS-1:0]    io_buttons;
    logic [mfp_pkg::MFP_N_RED_LEDS-1:0]   io_red_leds;
    logic [mfp_pkg::MFP_N_GREEN_LEDS-1:0] io_green_leds;
    logic [mfp_pkg::MFP_HEX_WIDTH-1:0]    io_hex;
    logic                                 ext_irq;
    logic                                 irq_ack;
    logic                                 irq_valid;
    mfp_pkg::irq_vec_t                    irq_vector;
    logic                                 si_cold_reset;
    logic                                 si_reset;

    int          seed = 19;
    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          test_base = 0;       // error count when the current test began
    logic [31:0] ram_model [2**RAM_ADDR_BITS];
    logic [31:0] hex_model;
    logic [mfp_pkg::MFP_N_RED_LEDS-1:0]   red_exp;
    logic [mfp_pkg::MFP_N_GREEN_LEDS-1:0] green_exp;
    logic [7:0]  exp_mask;            // eic mask as last written
    logic [31:0] d;
    logic [31:0] rd;
    logic [3:0]  s;
    logic        er;
    mfp_pkg::irq_vec_t ack_order [3] = '{3'(mfp_pkg::EIC_CH_EXT), 3'(mfp_pkg::EIC_CH_BTN),
                                         3'(mfp_pkg::EIC_CH_SW1)};  // priority order

    mfp_system #(.RAM_ADDR_BITS (RAM_ADDR_BITS)) mfp_system_inst (.*);

    initial begin
        hclk = 1'b0;
        forever #(PERIOD / 2) hclk = ~hclk;
    end

    initial begin
        #(N_XFERS * 20 * PERIOD + RESET_TIME);
        $display("watchdog expired, the run did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

    task automatic flag_error(input string msg);
        errors++;
        $display("** Error @%0t: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_base) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", tests, name, errors - test_base);
        end
        test_base = errors;
    endtask

    // byte lanes of new_w replace old_w where strobed
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w, input logic [3:0] strb);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    // one request, then the response taken after a random stall
    task automatic transfer(input logic [31:0] addr, input logic [31:0] wdata, input logic write,
                            input logic [3:0] strb, output logic [31:0] rdata, output logic err);
        int stall;
        stall = $unsigned($random(seed)) % 4;   // cycles of rsp back-pressure
        @(negedge hclk);
        req.addr  = addr;
        req.wdata = wdata;
        req.write = write;
        req.strb  = strb;
        req_valid = 1'b1;
        rsp_ready = (stall == 0);
        while (!req_ready)
            @(negedge hclk);
        @(posedge hclk);                        // accepting edge
        if (write && addr == EIC + mfp_pkg::EIC_MASK)
            exp_mask = wdata[7:0];
        @(negedge hclk);
        req_valid = 1'b0;
        assert (rsp_valid) else flag_error("no response one cycle after acceptance");
        repeat (stall) @(negedge hclk);
        rsp_ready = 1'b1;
        rdata     = rsp.rdata;
        err       = rsp.err;
        @(posedge hclk);                        // response taken
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic [31:0] unused_rd;
        logic        err;
        transfer(addr, data, 1'b1, strb, unused_rd, err);
        assert (!err) else flag_error($sformatf("error flag on write to 0x%08h", addr));
    endtask

    task automatic read_check(input logic [31:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] got;
        logic        err;
        transfer(addr, 32'h0, 1'b0, 4'h0, got, err);
        assert (!err && got === exp)
            else flag_error($sformatf("%s read 0x%08h err %0b, expected 0x%08h",
                                      what, got, err, exp));
    endtask

    // response one cycle after acceptance
    accept_rsp: assert property (@(posedge hclk) disable iff (si_reset !== 1'b0)
        req_valid && req_ready |=> rsp_valid)
        else flag_error("rsp_valid did not follow acceptance");
    // back-pressure blocks new requests and freezes the response
    stall_hold: assert property (@(posedge hclk) disable iff (si_reset !== 1'b0)
        rsp_valid && !rsp_ready |-> !req_ready ##1 (rsp_valid && $stable(rsp)))
        else flag_error("req_ready high or response changed under back-pressure");
    mask_gate: assert property (@(posedge hclk) disable iff (si_reset !== 1'b0)
        irq_valid |-> exp_mask[irq_vector])
        else flag_error($sformatf("irq_valid on disabled channel %0d", irq_vector));

    initial begin
        rst          = 1'b1;
        pin_rst_soft = 1'b0;
        req          = '0;
        req_valid    = 1'b0;
        rsp_ready    = 1'b1;
        io_switches  = '0;
        io_buttons   = 4'b1010;   // steady from time zero, no edge after reset
        ext_irq      = 1'b0;
        irq_ack      = 1'b0;
        exp_mask     = '0;
        repeat (4) @(negedge hclk);
        rst = 1'b0;
        @(negedge hclk);
        while (si_reset !== 1'b0)
            @(negedge hclk);

        assert (io_red_leds === '0 && io_green_leds === '0 && io_hex === '0)
            else flag_error("led or hex outputs not zero after reset");
        assert (irq_valid === 1'b0 && req_ready === 1'b1 && rsp_valid === 1'b0)
            else flag_error("bus or irq handshake wrong after reset");
        end_test("reset state");

        for (int i = 0; i < N_RAM; i++) begin
            d = $random(seed);
            write_word(32'(i * 31 * 4), d, 4'hF);   // full word first
            ram_model[i * 31] = d;
            d = $random(seed);
            s = $random(seed);
            write_word(32'(i * 31 * 4), d, s);
            ram_model[i * 31] = merge_bytes(ram_model[i * 31], d, s);
            read_check(32'(i * 31 * 4), ram_model[i * 31], "ram");
        end
        read_check(32'h0FFF_FC00, ram_model[0], "ram alias");  // wraps onto word 0
        end_test("ram strobes");

        d = $random(seed);
        write_word(GPIO + mfp_pkg::GPIO_RED, d, 4'hF);
        red_exp = d[mfp_pkg::MFP_N_RED_LEDS-1:0];
        assert (io_red_leds === red_exp) else flag_error("red leds wrong after write");
        d = $random(seed);
        write_word(GPIO + mfp_pkg::GPIO_GREEN, d, 4'hF);
        green_exp = d[mfp_pkg::MFP_N_GREEN_LEDS-1:0];
        assert (io_green_leds === green_exp) else flag_error("green leds wrong after write");
        read_check(GPIO + mfp_pkg::GPIO_RED, 32'(red_exp), "red leds");
        hex_model = $random(seed);
        write_word(GPIO + mfp_pkg::GPIO_HEX, hex_model, 4'hF);
        d = $random(seed);
        s = $random(seed);
        write_word(GPIO + mfp_pkg::GPIO_HEX, d, s);
        hex_model = merge_bytes(hex_model, d, s);
        assert (io_hex === hex_model) else flag_error("hex output does not follow strobes");
        read_check(GPIO + mfp_pkg::GPIO_HEX, hex_model, "hex");
        @(negedge hclk);
        io_switches = $random(seed);
        read_check(GPIO + mfp_pkg::GPIO_SW, 32'(io_switches), "switches");
        read_check(GPIO + mfp_pkg::GPIO_BTN, 32'(4'b1010), "buttons");
        end_test("gpio");

        transfer(32'h2000_0000, 32'hFFFF_FFFF, 1'b1, 4'hF, rd, er);
        assert (er && rd === 32'h0) else flag_error("unmapped write gave no error response");
        transfer(32'h2000_0000, 32'h0, 1'b0, 4'h0, rd, er);
        assert (er && rd === 32'h0) else flag_error("unmapped read gave no error response");
        read_check(32'h0, ram_model[0], "ram after unmapped write");
        assert (io_red_leds === red_exp && io_hex === hex_model)
            else flag_error("unmapped write changed gpio outputs");
        end_test("unmapped");

        @(negedge hclk);
        ext_irq = 1'b1;                          // channel 7 edge, mask still zero
        write_word(EIC + mfp_pkg::EIC_SWINT, 32'h2, 4'hF);
        @(negedge hclk);
        io_buttons = 4'b1011;                    // button edge into channel 5
        repeat (4) @(negedge hclk);
        assert (!irq_valid) else flag_error("irq_valid high with every channel disabled");
        read_check(EIC + mfp_pkg::EIC_PEND, 32'h0000_00A2, "eic pending");
        write_word(EIC + mfp_pkg::EIC_MASK, 32'hFF, 4'hF);
        foreach (ack_order[k]) begin
            @(negedge hclk);
            assert (irq_valid && irq_vector === ack_order[k])
                else flag_error($sformatf("vector %0d valid %0b, expected %0d",
                                          irq_vector, irq_valid, ack_order[k]));
            irq_ack = irq_valid;                 // ack only what is presented
        end
        @(negedge hclk);
        irq_ack = 1'b0;
        assert (!irq_valid) else flag_error("irq_valid still high after all acks");
        write_word(EIC + mfp_pkg::EIC_MASK, 32'h7F, 4'hF);
        @(negedge hclk);
        ext_irq = 1'b0;
        @(negedge hclk);
        ext_irq = 1'b1;                          // pends on a disabled channel
        repeat (3) @(negedge hclk);
        assert (!irq_valid) else flag_error("disabled channel 7 raised irq_valid");
        read_check(EIC + mfp_pkg::EIC_PEND, 32'h0000_0080, "eic pending ch7");
        end_test("eic priority");

        @(negedge hclk);
        pin_rst_soft = 1'b1;
        repeat (3) @(negedge hclk);              // through the synchronizer
        assert (si_reset === 1'b1 && si_cold_reset === 1'b0)
            else flag_error("soft reset did not raise si_reset alone");
        exp_mask     = '0;
        pin_rst_soft = 1'b0;
        while (si_reset !== 1'b0) begin
            assert (si_cold_reset === 1'b0) else flag_error("soft reset raised si_cold_reset");
            @(negedge hclk);
        end
        assert (io_red_leds === red_exp && io_green_leds === green_exp && io_hex === hex_model)
            else flag_error("soft reset changed gpio outputs");
        read_check(EIC + mfp_pkg::EIC_MASK, 32'h0, "eic mask after soft reset");
        read_check(EIC + mfp_pkg::EIC_PEND, 32'h0, "eic pending after soft reset");
        read_check(32'(31 * 4), ram_model[31], "ram after soft reset");
        end_test("soft reset");

        $display("tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: filelist.f
mfp_pkg.sv
mfp_reset.sv
mfp_bus_matrix.sv
mfp_ram.sv
mfp_gpio.sv
mfp_eic.sv
mfp_system.sv
tb_mfp_system.sv
